/* vlog.f */
ubaPkg.sv
ubaDecode.sv
ubaDevice.sv
ubaCollect.sv
ubaNxd.sv
ubaStatus.sv
ubaTop.sv
ubaTb.sv

/* Bender.yml */
package:
  name: uba_slice

sources:
  - ubaPkg.sv
  - ubaDecode.sv
  - ubaDevice.sv
  - ubaCollect.sv
  - ubaNxd.sv
  - ubaStatus.sv
  - ubaTop.sv
  - target: simulation
    files:
      - ubaTb.sv

/* ubaTb.sv */
// Unibus adapter slice testbench
// Round trips, ack delays, NXD timeout, CSR, WRU poll and back-pressure

`timescale 1ns/10ps

module ubaTb;

   logic clk;
   logic rst;
   logic busReq;
   ubaPkg::ubaReqT busReqWord;
   logic busAck;
   ubaPkg::ubaRspT busRsp;
   logic nxd;
   logic [ubaPkg::numDevices-1:0] intReq;

   int seed;
   int rnd;
   int failCount;
   int failMark;
   int testsOk;
   int testsBad;
   int cycleCount;
   int nxdCount;
   int mark;
   int latency;
   logic gotNxd;
   logic expectAck;
   logic expectNxd;
   logic [ubaPkg::dataWidth-1:0] rdata;
   // Scoreboard of register 1 contents
   logic [ubaPkg::dataWidth-1:0] stored [ubaPkg::numDevices];
   int ackDev [3] = '{0, 1, 3};
   int ackDelay [3] = '{0, 5, 10};

   ubaTop dut0 (
      .clk(clk), .rst(rst), .busReq(busReq), .busReqWord(busReqWord),
      .busAck(busAck), .busRsp(busRsp), .nxd(nxd), .intReq(intReq)
   );

   always #50 clk = ~clk;

   // About 40 transfers of at most 30 cycles, 2000 is a safe ceiling
   always @(posedge clk)
   begin
      cycleCount++;
      if (nxd)
         nxdCount++;
      if (cycleCount >= 2000)
      begin
         $display("Run stopped after 2000 cycles without reaching the end of the tests");
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic logError(input string msg);
      failCount++;
      $display("FAILED %0t: %s", $time, msg);
   endtask

   //////////////////////////////
   // Bus protocol checks
   //////////////////////////////

   ackNeedsReq : assert property (@(posedge clk) disable iff (rst) busAck |-> busReq)
      else logError("busAck without busReq");
   rspAckIsAck : assert property (@(posedge clk) disable iff (rst) busRsp.ack == busAck)
      else logError("busRsp.ack does not follow busAck");
   ackOrNxd : assert property (@(posedge clk) disable iff (rst) !(busAck && nxd))
      else logError("busAck and nxd together");
   nxdOneCycle : assert property (@(posedge clk) disable iff (rst) nxd |=> !nxd)
      else logError("nxd longer than one cycle");
   noNxdInLimit : assert property (@(posedge clk) disable iff (rst) expectAck |-> !nxd)
      else logError("nxd on a device inside the ack limit");
   noAckOnTimeout : assert property (@(posedge clk) disable iff (rst) expectNxd |-> !busAck)
      else logError("busAck on a request that should time out");

   function automatic ubaPkg::ubaReqT regRequest(input int slot, input int sel,
         input logic write, input logic [ubaPkg::dataWidth-1:0] wdata);
      ubaPkg::ubaReqT word;
      word = '0;
      word.addr.regView.slot = slot[ubaPkg::slotWidth-1:0];
      word.addr.regView.register = sel[ubaPkg::regSelWidth-1:0];
      word.write = write;
      word.wdata = wdata;
      return word;
   endfunction

   function automatic ubaPkg::ubaReqT wruRequest(input logic [ubaPkg::numDevices-1:0] mask);
      ubaPkg::ubaReqT word;
      word = '0;
      word.wru = 1'b1;
      word.addr.wruView.levelMask = mask;
      return word;
   endfunction

   task automatic expectEqual(input string what, input int got, input int exp);
      assert (got == exp)
         else logError($sformatf("%s is %0h, expected %0h", what, got, exp));
   endtask

   // Starts at a drive point, waits for busAck or nxd up to maxWait cycles
   task automatic busTransfer(input ubaPkg::ubaReqT word, input int holdCycles,
         input int maxWait);
      logic done;
      done = 1'b0;
      gotNxd = 1'b0;
      latency = 0;
      busReqWord = word;
      busReq = 1'b1;
      while (!done && latency < maxWait)
      begin
         @(posedge clk);
         #5;
         latency++;
         if (busAck)
         begin
            done = 1'b1;
            rdata = busRsp.rdata;
         end
         else if (nxd)
         begin
            done = 1'b1;
            gotNxd = 1'b1;
         end
      end
      // Master keeps the request up past busAck
      if (busAck)
      begin
         repeat (holdCycles)
         begin
            @(posedge clk);
            #5;
            assert (busAck && busRsp.rdata == rdata)
               else logError("busAck or read data lost while request held");
         end
      end
      busReq = 1'b0;
      @(posedge clk);
      #5;
   endtask

   task automatic writeReg(input int slot, input int sel, input logic [15:0] data);
      busTransfer(regRequest(slot, sel, 1'b1, data), 0, 30);
      expectEqual("write nxd", gotNxd, 0);
   endtask

   task automatic readCheck(input int slot, input int sel, input logic [15:0] exp,
         input string what);
      busTransfer(regRequest(slot, sel, 1'b0, '0), 0, 30);
      expectEqual({what, " nxd"}, gotNxd, 0);
      expectEqual(what, rdata, exp);
   endtask

   task automatic finishTest(input string name);
      if (failCount == failMark)
      begin
         testsOk++;
         $display("Test %s: ok", name);
      end
      else
      begin
         testsBad++;
         $display("Test %s: %0d check(s) failed", name, failCount - failMark);
      end
      failMark = failCount;
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial
   begin
      clk = 1'b0;
      rst = 1'b1;
      busReq = 1'b0;
      busReqWord = '0;
      seed = 45;
      failCount = 0;
      failMark = 0;
      testsOk = 0;
      testsBad = 0;
      cycleCount = 0;
      nxdCount = 0;
      expectAck = 1'b0;
      expectNxd = 1'b0;
      repeat (16) @(posedge clk);
      #5;
      rst = 1'b0;
      @(posedge clk);
      #5;

      // Data in, same data and its inverse out
      for (int i = 0; i < ubaPkg::numDevices; i++)
      begin
         rnd = $random(seed);
         stored[i] = rnd[15:0];
         writeReg(i, 1, stored[i]);
         readCheck(i, 1, stored[i], "reg 1 data");
         readCheck(i, 3, ~stored[i], "reg 3 inverse");
      end
      finishTest("register round trip");

      // busAck one cycle after the device ack
      expectAck = 1'b1;
      for (int i = 0; i < 3; i++)
      begin
         writeReg(ackDev[i], 0, ackDelay[i]);
         readCheck(ackDev[i], 1, stored[ackDev[i]], "delayed read data");
         expectEqual("ack latency", latency, ackDelay[i] + 1);
      end
      expectAck = 1'b0;
      finishTest("ack within limit");

      // Device 2 is left too slow from here on
      writeReg(2, 0, 12);
      expectNxd = 1'b1;
      mark = nxdCount;
      busTransfer(regRequest(2, 1, 1'b0, '0), 0, 30);
      expectEqual("slow device nxd", gotNxd, 1);
      expectEqual("nxd cycle", latency, ubaPkg::nxdLimit);
      repeat (14) @(posedge clk);
      #5;
      expectEqual("nxd pulses", nxdCount - mark, 1);
      // Empty slot has no responder and times out too
      mark = nxdCount;
      busTransfer(regRequest(5, 0, 1'b0, '0), 0, 30);
      expectEqual("empty slot nxd", gotNxd, 1);
      expectEqual("empty slot nxd cycle", latency, ubaPkg::nxdLimit);
      repeat (14) @(posedge clk);
      #5;
      expectEqual("empty slot nxd pulses", nxdCount - mark, 1);
      expectNxd = 1'b0;
      readCheck(ubaPkg::statusSlot, 0, 16'h0001, "status after timeout");
      finishTest("nxd timeout");

      // Flag clear by writing one, scratch in bits 7..4
      writeReg(ubaPkg::statusSlot, 0, 16'h00a1);
      readCheck(ubaPkg::statusSlot, 0, 16'h00a0, "status clear");
      writeReg(ubaPkg::statusSlot, 0, 16'h0050);
      readCheck(ubaPkg::statusSlot, 0, 16'h0050, "status scratch");
      finishTest("status register");

      writeReg(1, 2, 16'h0001);
      writeReg(3, 2, 16'h0001);
      expectEqual("intReq", intReq, 4'b1010);
      busTransfer(wruRequest(4'b1010), 0, 30);
      expectEqual("WRU latency", latency, 1);
      expectEqual("WRU vector both", rdata, ubaPkg::vectorBase + 4 * 1);
      busTransfer(wruRequest(4'b1000), 0, 30);
      expectEqual("WRU vector device 3", rdata, ubaPkg::vectorBase + 4 * 3);
      finishTest("WRU poll");

      // Held write and held read on device 0
      rnd = $random(seed);
      stored[0] = rnd[15:0];
      busTransfer(regRequest(0, 1, 1'b1, stored[0]), 5, 30);
      expectEqual("held write nxd", gotNxd, 0);
      busTransfer(regRequest(0, 1, 1'b0, '0), 3, 30);
      expectEqual("held read data", rdata, stored[0]);
      finishTest("back-pressure");

      $display("Tests: %0d ok, %0d failed, %0d failed checks", testsOk, testsBad, failCount);
      if (failCount == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

/* ubaTop.sv */
// Unibus adapter slice top level
// Decoder, four devices, response collector, CSR and NXD timer

`timescale 1ns/10ps

module ubaTop (
   input  logic clk,
   input  logic rst,
   input  logic busReq,
   input  ubaPkg::ubaReqT busReqWord,
   output logic busAck,
   output ubaPkg::ubaRspT busRsp,
   output logic nxd,
   output logic [ubaPkg::numDevices-1:0] intReq
);

   logic [ubaPkg::numDevices-1:0] devReq;
   logic staReq;
   logic wruReq;
   logic wruAck;
   logic setNxd;
   logic [ubaPkg::dataWidth-1:0] wruVector;
   ubaPkg::ubaRspT slotRsp [ubaPkg::numDevices];
   ubaPkg::ubaRspT devRsp;
   ubaPkg::ubaRspT staRsp;

   ubaDecode decode0 (
      .busReq(busReq), .busReqWord(busReqWord),
      .devReq(devReq), .staReq(staReq), .wruReq(wruReq)
   );

   //////////////////////////////
   // Device slots
   //////////////////////////////

   for (genvar i = 0; i < ubaPkg::numDevices; i++)
   begin : gDev
      ubaDevice dev (
         .clk(clk), .rst(rst), .req(devReq[i]), .reqWord(busReqWord),
         .rsp(slotRsp[i]), .intr(intReq[i])
      );
   end

   ubaCollect collect0 (
      .devRsp(slotRsp), .devIntr(intReq), .reqWord(busReqWord), .wruReq(wruReq),
      .rsp(devRsp), .wruAck(wruAck), .wruVector(wruVector)
   );

   ubaStatus status0 (
      .clk(clk), .rst(rst), .req(staReq), .reqWord(busReqWord),
      .setNxd(setNxd), .rsp(staRsp)
   );

   // Any device slot counts as a device request
   ubaNxd nxd0 (
      .clk(clk), .rst(rst), .busReq(busReq),
      .ubaReq(staReq), .ubaAck(staRsp.ack),
      .devReq(|devReq), .devAck(devRsp.ack),
      .wruReq(wruReq), .wruAck(wruAck),
      .busAck(busAck), .setNxd(setNxd)
   );

   //////////////////////////////
   // Bus response
   //////////////////////////////

   // Only the acking responder drives nonzero data
   always_comb
   begin
      busRsp.ack   = busAck;
      busRsp.rdata = devRsp.rdata | staRsp.rdata | wruVector;
   end

   assign nxd = setNxd;

endmodule

/* ubaStatus.sv */
// Unibus adapter control/status register
// Sticky NXD flag in bit 0, scratch field in bits 7..4

`timescale 1ns/10ps

module ubaStatus (
   input  logic clk,
   input  logic rst,
   input  logic req,
   input  ubaPkg::ubaReqT reqWord,
   input  logic setNxd,
   output ubaPkg::ubaRspT rsp
);

   logic nxdFlag;
   logic [3:0] scratch;
   logic served;
   logic wrStrobe;
   logic [ubaPkg::dataWidth-1:0] readVal;

   // Acked in the request cycle, written once
   assign wrStrobe = req & ~served & reqWord.write;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         nxdFlag <= 1'b0;
         scratch <= '0;
         served  <= 1'b0;
      end
      else
      begin
         served <= req;
         // Timeout beats a clear in the same cycle
         if (setNxd)
            nxdFlag <= 1'b1;
         else if (wrStrobe && reqWord.wdata[0])
            nxdFlag <= 1'b0;
         if (wrStrobe)
            scratch <= reqWord.wdata[7:4];
      end
   end

   always_comb
   begin
      readVal      = '0;
      readVal[0]   = nxdFlag;
      readVal[7:4] = scratch;
      rsp.ack      = req;
      rsp.rdata    = req ? readVal : '0;
   end

endmodule

/* ubaNxd.sv */
// Unibus non-existent device timer
// Waits up to eleven cycles for the selected ack, then either
// acknowledges the bus or pulses NXD for one cycle

`timescale 1ns/10ps

module ubaNxd (
   input  logic clk,
   input  logic rst,
   input  logic busReq,
   input  logic ubaReq,
   input  logic ubaAck,
   input  logic devReq,
   input  logic devAck,
   input  logic wruReq,
   input  logic wruAck,
   output logic busAck,
   output logic setNxd
);

   ubaPkg::nxdStateT state;
   // Adapter CSR addressed rather than a device
   logic uba;
   logic selAck;

   assign selAck = uba ? ubaAck : devAck;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         uba   <= 1'b0;
         state <= ubaPkg::stNull;
      end
      else
      begin
         case (state)
            ubaPkg::stNull:
            begin
               // CSR first, then devices, then WRU
               if (busReq & ubaReq)
               begin
                  uba   <= 1'b1;
                  state <= ubaAck ? ubaPkg::stAck : ubaPkg::stCnt0;
               end
               else if (busReq & devReq)
               begin
                  uba   <= 1'b0;
                  state <= devAck ? ubaPkg::stAck : ubaPkg::stCnt0;
               end
               // Empty slot has no responder and runs into NXD
               else if (busReq & ~wruReq)
               begin
                  uba   <= 1'b0;
                  state <= ubaPkg::stCnt0;
               end
               // Unmatched WRU just waits here
               else if (busReq & wruReq & wruAck)
                  state <= ubaPkg::stAck;
            end
            // Hold until the master lets go
            ubaPkg::stAck:
               if (!busReq)
                  state <= ubaPkg::stNull;
            ubaPkg::stNxd:
               state <= ubaPkg::stNull;
            // Count states
            default:
               if (selAck)
                  state <= ubaPkg::stAck;
               else if (state == ubaPkg::nxdStateT'(ubaPkg::nxdLimit - 1))
                  state <= ubaPkg::stNxd;
               else
                  state <= ubaPkg::nxdStateT'(state + 1'b1);
         endcase
      end
   end

   assign setNxd = (state == ubaPkg::stNxd);
   assign busAck = (state == ubaPkg::stAck) & busReq;

   nxdOnePulse : assert property (@(posedge clk) disable iff (rst) setNxd |=> !setNxd)
      else $error("ubaNxd: NXD longer than one cycle");
   // busAck only opens after some responder acked
   ackAfterResp : assert property (@(posedge clk) disable iff (rst)
      $rose(busAck) |-> $past(ubaAck | devAck | wruAck))
      else $error("ubaNxd: busAck without a responder ack");

endmodule

/* ubaCollect.sv */
// Unibus response collector
// ORs the device responses and answers WRU polls with the
// vector of the lowest pending device inside the level mask

`timescale 1ns/10ps

module ubaCollect (
   input  ubaPkg::ubaRspT devRsp [ubaPkg::numDevices],
   input  logic [ubaPkg::numDevices-1:0] devIntr,
   input  ubaPkg::ubaReqT reqWord,
   input  logic wruReq,
   output ubaPkg::ubaRspT rsp,
   output logic wruAck,
   output logic [ubaPkg::dataWidth-1:0] wruVector
);

   logic [ubaPkg::numDevices-1:0] pending;
   logic [ubaPkg::devIdxWidth-1:0] winner;
   logic [ubaPkg::dataWidth-1:0] vecOffset;

   //////////////////////////////
   // Register responses
   //////////////////////////////

   // Idle devices drive zero, so a plain OR merges them
   always_comb
   begin
      rsp = '0;
      for (int i = 0; i < ubaPkg::numDevices; i++)
      begin
         rsp.ack   = rsp.ack | devRsp[i].ack;
         rsp.rdata = rsp.rdata | devRsp[i].rdata;
      end
   end

   //////////////////////////////
   // WRU poll
   //////////////////////////////

   // Levels that are both raised and polled
   assign pending = devIntr & reqWord.addr.wruView.levelMask;

   // Scan downward so the lowest device wins
   always_comb
   begin
      winner = '0;
      for (int i = ubaPkg::numDevices - 1; i >= 0; i--)
      begin
         if (pending[i])
            winner = i[ubaPkg::devIdxWidth-1:0];
      end
      // Four bytes between vectors
      vecOffset = '0;
      vecOffset[ubaPkg::devIdxWidth+1:0] = {winner, 2'b00};
   end

   // No match leaves the poll unanswered
   assign wruAck = wruReq & (|pending);

   assign wruVector = wruAck ? (ubaPkg::vectorBase + vecOffset) : '0;

endmodule

/* ubaDevice.sv */
// Unibus I/O device model
// Four plain registers, software-programmed ack delay,
// one interrupt request level

`timescale 1ns/10ps

module ubaDevice (
   input  logic clk,
   input  logic rst,
   input  logic req,
   input  ubaPkg::ubaReqT reqWord,
   output ubaPkg::ubaRspT rsp,
   output logic intr
);

   logic [ubaPkg::delayWidth-1:0] delay;
   logic [ubaPkg::delayWidth-1:0] count;
   logic [ubaPkg::regSelWidth-1:0] regSel;
   logic [ubaPkg::dataWidth-1:0] data;
   logic [ubaPkg::dataWidth-1:0] readVal;
   logic served;
   logic intCtl;
   logic ack;
   logic wrStrobe;

   assign regSel = reqWord.addr.regView.register;

   // Ack once the count reaches the delay, then hold it for the rest
   // of the request so a delay rewrite cannot drop it
   assign ack = req & (served | (count == delay));

   // Only the first ack cycle writes
   assign wrStrobe = ack & ~served & reqWord.write;

   //////////////////////////////
   // Control registers
   //////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         count  <= '0;
         served <= 1'b0;
         delay  <= '0;
         intCtl <= 1'b0;
      end
      else
      begin
         // Counter follows the request level
         if (!req)
         begin
            count  <= '0;
            served <= 1'b0;
         end
         else if (ack)
            served <= 1'b1;
         else
            count <= count + 1'b1;

         // Reg 0 delay, reg 2 interrupt control
         if (wrStrobe && regSel == 2'd0)
            delay <= reqWord.wdata[ubaPkg::delayWidth-1:0];
         if (wrStrobe && regSel == 2'd2)
            intCtl <= reqWord.wdata[0];
      end
   end

   // Data register
   always_ff @(posedge clk)
   begin
      if (wrStrobe && regSel == 2'd1)
         data <= reqWord.wdata;
   end

   //////////////////////////////
   // Read mux
   //////////////////////////////

   always_comb
   begin
      readVal = '0;
      case (regSel)
         2'd0: readVal[ubaPkg::delayWidth-1:0] = delay;
         2'd1: readVal = data;
         2'd2: readVal[0] = intCtl;
         // Reg 3 mirrors the data inverted
         default: readVal = ~data;
      endcase
      // Read data only while acked so the collector can OR
      rsp.ack   = ack;
      rsp.rdata = ack ? readVal : '0;
   end

   assign intr = intCtl;

   // Held request keeps its ack
   devAckHeld : assert property (@(posedge clk) disable iff (rst)
      rsp.ack |=> rsp.ack || !req)
      else $error("ubaDevice: ack dropped while request held");

endmodule

/* ubaDecode.sv */
// Unibus adapter address decoder
// Splits the bus request into per-slot device requests,
// the adapter CSR request and the WRU poll request

`timescale 1ns/10ps

module ubaDecode (
   input  logic busReq,
   input  ubaPkg::ubaReqT busReqWord,
   output logic [ubaPkg::numDevices-1:0] devReq,
   output logic staReq,
   output logic wruReq
);

   logic [ubaPkg::slotWidth-1:0] slot;
   logic regAccess;

   //////////////////////////////
   // Field extraction
   //////////////////////////////

   // Slot number from the register view
   assign slot = busReqWord.addr.regView.slot;

   // WRU flag overrides any slot decode
   assign regAccess = busReq & ~busReqWord.wru;

   //////////////////////////////
   // Request steering
   //////////////////////////////

   always_comb
   begin
      devReq = '0;
      // One level per populated slot
      for (int i = 0; i < ubaPkg::numDevices; i++)
      begin
         if (slot == i)
         begin
            devReq[i] = regAccess;
         end
      end
   end

   // Adapter's own CSR
   assign staReq = regAccess & (slot == ubaPkg::statusSlot);

   // Interrupt poll ignores the slot field
   assign wruReq = busReq & busReqWord.wru;

   // Empty slots 4..6 fall through here with no request at all,
   // which leaves the timer to raise NXD

endmodule

/* ubaPkg.sv */
// Unibus adapter shared definitions
// Bus sizes, slot map, request and response words, NXD timer states

package ubaPkg;

   //////////////////////////////
   // Sizes
   //////////////////////////////

   // Device slots actually built
   localparam int numDevices = 4;
   // Bus data and address words
   localparam int dataWidth = 16;
   localparam int addrWidth = 16;
   // Address fields in the register view
   localparam int slotWidth = 3;
   localparam int regSelWidth = 2;
   // Programmable ack delay in each device
   localparam int delayWidth = 4;
   // Index of one device slot
   localparam int devIdxWidth = $clog2(numDevices);

   // Adapter's own CSR lives in the top slot, slots 4..6 stay empty
   localparam logic [slotWidth-1:0] statusSlot = 3'd7;

   // NULL state plus ten count states
   localparam int nxdLimit = 11;

   // Device n answers a WRU poll with vectorBase + 4n
   localparam logic [dataWidth-1:0] vectorBase = 16'o000300;

   //////////////////////////////
   // Address word
   //////////////////////////////

   // Register access view
   typedef struct packed {
      logic [slotWidth-1:0] slot;
      logic [regSelWidth-1:0] register;
      logic [addrWidth-slotWidth-regSelWidth-1:0] rsvd;
   } ubaRegViewT;

   // WRU poll view, one mask bit per device level
   typedef struct packed {
      logic [numDevices-1:0] levelMask;
      logic [addrWidth-numDevices-1:0] rsvd;
   } ubaWruViewT;

   // Same address bits, read one of two ways
   typedef union packed {
      ubaRegViewT regView;
      ubaWruViewT wruView;
   } ubaAddrT;

   //////////////////////////////
   // Bus words
   //////////////////////////////

   typedef struct packed {
      ubaAddrT addr;
      logic write;
      logic wru;
      logic [dataWidth-1:0] wdata;
   } ubaReqT;

   typedef struct packed {
      logic ack;
      logic [dataWidth-1:0] rdata;
   } ubaRspT;

   // Timer states, count states run 1..10
   typedef enum logic [3:0] {
      stNull, stCnt0, stCnt1, stCnt2, stCnt3, stCnt4,
      stCnt5, stCnt6, stCnt7, stCnt8, stCnt9, stNxd, stAck
   } nxdStateT;

endpackage
